//--- Makefile
VERILATOR ?= verilator
TOP       := tb_compute_tile
FILELIST  := compute_tile.f
BUILD_DIR := obj_dir
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- compute_tile.f
+incdir+hdl
hdl/wb_pkg.sv
hdl/tile_pkg.sv
hdl/wb_bus_arbiter.sv
hdl/wb_bus_decode.sv
hdl/wb_sram_sp.sv
hdl/bootrom.sv
hdl/compute_tile.sv
testbench/tb_compute_tile.sv

//--- hdl/bootrom.sv
// Read-only boot code Wishbone slave that errors on writes
`timescale 1ns/1ps
`default_nettype none

`include "tile_params.svh"

module bootrom
   import wb_pkg::*;
   import tile_pkg::*;
(
   input  wire          clk,
   input  wire          rst_n_i,
   input  wire wb_req_t wb_req_i,
   output wb_rsp_t      wb_rsp_o
);

   localparam int IDXW = $clog2(`BOOTROM_WORDS);

   logic [IDXW-1:0] idx;
   logic            req_vld;
   logic            ack_q;
   logic            err_q;
   wb_dat_t         dat_q;

   assign idx     = wb_req_i.adr[IDXW+1:2];
   assign req_vld = wb_req_i.cyc && wb_req_i.stb && !(ack_q || err_q);

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ack_q <= 1'b0;
         err_q <= 1'b0;
      end else begin
         ack_q <= req_vld && !wb_req_i.we;
         err_q <= req_vld && wb_req_i.we;  // Writes are refused
      end
   end

   always_ff @(posedge clk) begin
      dat_q <= bootrom_image[idx];
   end

   assign wb_rsp_o = '{dat: dat_q, ack: ack_q, err: err_q};

endmodule

`default_nettype wire

//--- hdl/compute_tile.sv
// Compute tile bus core joining two masters to data memory and boot ROM
`timescale 1ns/1ps
`default_nettype none

`include "tile_params.svh"

module compute_tile
   import wb_pkg::*;
(
   input  wire                              clk,
   input  wire                              rst_n_i,
   input  wire wb_req_t [`NR_MASTERS-1:0]   m_req_i,
   output wb_rsp_t [`NR_MASTERS-1:0]        m_rsp_o,
   output logic                             snoop_en_o,
   output wb_adr_t                          snoop_adr_o
);

   wb_req_t bus_req;
   wb_rsp_t bus_rsp;
   wb_req_t mem_req;
   wb_rsp_t mem_rsp;
   wb_req_t rom_req;
   wb_rsp_t rom_rsp;

   wb_bus_arbiter u_arbiter (
      .clk       (clk),
      .rst_n_i   (rst_n_i),
      .m_req_i   (m_req_i),
      .m_rsp_o   (m_rsp_o),
      .bus_req_o (bus_req),
      .bus_rsp_i (bus_rsp)
   );

   wb_bus_decode u_decode (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .bus_req_i   (bus_req),
      .bus_rsp_o   (bus_rsp),
      .mem_req_o   (mem_req),
      .mem_rsp_i   (mem_rsp),
      .rom_req_o   (rom_req),
      .rom_rsp_i   (rom_rsp),
      .snoop_en_o  (snoop_en_o),
      .snoop_adr_o (snoop_adr_o)
   );

   wb_sram_sp #(
      .MEM_SIZE_BYTE (`LMEM_SIZE)
   ) u_ram (
      .clk      (clk),
      .rst_n_i  (rst_n_i),
      .wb_req_i (mem_req),
      .wb_rsp_o (mem_rsp)
   );

   bootrom u_bootrom (
      .clk      (clk),
      .rst_n_i  (rst_n_i),
      .wb_req_i (rom_req),
      .wb_rsp_o (rom_rsp)
   );

endmodule

`default_nettype wire

//--- hdl/tile_params.svh
// Compute tile parameters for bus widths, master count, memory size and address map
`ifndef TILE_PARAMS_SVH
`define TILE_PARAMS_SVH

// Wishbone widths
`define WB_AW 32
`define WB_DW 32
`define WB_SELW 4

// Bus masters on the shared bus
`define NR_MASTERS 2

// Local data memory size in bytes
`define LMEM_SIZE 4096

// Address map on the top nibble
`define DM_MATCH 4'h0
`define BOOT_MATCH 4'hf

// Boot code words
`define BOOTROM_WORDS 8

`endif

//--- hdl/tile_pkg.sv
// Tile address map types, slave select encoding and boot code image
`default_nettype none

`include "tile_params.svh"

package tile_pkg;

   import wb_pkg::*;

   typedef logic [$clog2(`NR_MASTERS)-1:0] master_idx_t;

   // Top address nibble
   typedef logic [3:0] region_t;

   typedef enum logic [1:0] {
      SLAVE_DM   = 2'd0,
      SLAVE_BOOT = 2'd1,
      SLAVE_NONE = 2'd2
   } slave_sel_t;

   // Small boot stub with every word distinct
   localparam wb_dat_t bootrom_image [`BOOTROM_WORDS] = '{
      32'h1800_0000,  // Clear base register
      32'ha820_0000,
      32'h1860_0000,
      32'ha863_0100,
      32'h1880_f000,
      32'ha884_0020,
      32'h4400_1800,  // Jump to loaded code
      32'h1500_0000
   };

endpackage

`default_nettype wire

//--- hdl/wb_bus_arbiter.sv
// Round-robin arbiter that grants the shared Wishbone bus and returns responses to the owner
`timescale 1ns/1ps
`default_nettype none

`include "tile_params.svh"

module wb_bus_arbiter
   import wb_pkg::*;
   import tile_pkg::*;
(
   input  wire                              clk,
   input  wire                              rst_n_i,
   input  wire wb_req_t [`NR_MASTERS-1:0]   m_req_i,
   output wb_rsp_t [`NR_MASTERS-1:0]        m_rsp_o,
   output wb_req_t                          bus_req_o,
   input  wire wb_rsp_t                     bus_rsp_i
);

   logic        owned_q;     // Some master holds the bus
   master_idx_t owner_q;
   master_idx_t last_q;      // Last master granted
   master_idx_t next_idx;
   master_idx_t cand;
   logic        found;
   logic        bus_free;

   // Search starts after the last served master
   always_comb begin
      next_idx = last_q;
      found    = 1'b0;
      for (int i = 1; i <= `NR_MASTERS; i++) begin
         cand = master_idx_t'((int'(last_q) + i) % `NR_MASTERS);
         if (!found && m_req_i[cand].cyc) begin
            next_idx = cand;
            found    = 1'b1;
         end
      end
   end

   // Owner gives up the bus by dropping cyc
   assign bus_free = !owned_q || !m_req_i[owner_q].cyc;

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         owned_q <= 1'b0;
         owner_q <= '0;
         last_q  <= master_idx_t'(`NR_MASTERS-1);
      end else if (bus_free) begin
         owned_q <= found;
         if (found) begin
            owner_q <= next_idx;
            last_q  <= next_idx;
         end
      end
   end

   assign bus_req_o = owned_q ? m_req_i[owner_q] : '0;

   for (genvar i = 0; i < `NR_MASTERS; i++) begin : g_rsp
      assign m_rsp_o[i] = (owned_q && owner_q == master_idx_t'(i)) ? bus_rsp_i : '0;

      // A response only ends a strobe this master issued while owning the bus
      a_rsp_owner : assert property (@(posedge clk) disable iff (!rst_n_i)
         (m_rsp_o[i].ack || m_rsp_o[i].err) |->
            $past(owned_q && owner_q == master_idx_t'(i) && m_req_i[i].stb));
   end

endmodule

`default_nettype wire

//--- hdl/wb_bus_decode.sv
// Address decoder steering the bus to the slaves, with error response and write snoop
`timescale 1ns/1ps
`default_nettype none

`include "tile_params.svh"

module wb_bus_decode
   import wb_pkg::*;
   import tile_pkg::*;
(
   input  wire          clk,
   input  wire          rst_n_i,
   input  wire wb_req_t bus_req_i,
   output wb_rsp_t      bus_rsp_o,
   output wb_req_t      mem_req_o,
   input  wire wb_rsp_t mem_rsp_i,
   output wb_req_t      rom_req_o,
   input  wire wb_rsp_t rom_rsp_i,
   output logic         snoop_en_o,
   output wb_adr_t      snoop_adr_o
);

   region_t    region;
   slave_sel_t sel;
   logic       req_vld;
   logic       err_q;        // Error pulse for unmapped access
   logic       snoop_en_q;
   wb_adr_t    snoop_adr_q;

   assign region  = bus_req_i.adr[`WB_AW-1 -: $bits(region_t)];
   assign req_vld = bus_req_i.cyc && bus_req_i.stb;

   always_comb begin
      case (region)
         `DM_MATCH:   sel = SLAVE_DM;
         `BOOT_MATCH: sel = SLAVE_BOOT;
         default:     sel = SLAVE_NONE;
      endcase
   end

   always_comb begin
      mem_req_o     = bus_req_i;
      rom_req_o     = bus_req_i;
      mem_req_o.stb = req_vld && (sel == SLAVE_DM);
      rom_req_o.stb = req_vld && (sel == SLAVE_BOOT);
   end

   always_comb begin
      bus_rsp_o.ack = mem_rsp_i.ack || rom_rsp_i.ack;
      bus_rsp_o.err = mem_rsp_i.err || rom_rsp_i.err || err_q;
      case (sel)
         SLAVE_DM:   bus_rsp_o.dat = mem_rsp_i.dat;
         SLAVE_BOOT: bus_rsp_o.dat = rom_rsp_i.dat;
         default:    bus_rsp_o.dat = '0;
      endcase
   end

   // Snoop tracks the memory ack rule, so it lands in the write's ack cycle
   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         err_q      <= 1'b0;
         snoop_en_q <= 1'b0;
      end else begin
         err_q      <= req_vld && (sel == SLAVE_NONE) && !err_q;
         snoop_en_q <= mem_req_o.stb && mem_req_o.we && !mem_rsp_i.ack;
      end
   end

   always_ff @(posedge clk) begin
      if (mem_req_o.stb && mem_req_o.we) begin
         snoop_adr_q <= bus_req_i.adr;
      end
   end

   assign snoop_en_o  = snoop_en_q;
   assign snoop_adr_o = snoop_adr_q;

   a_ack_err_excl : assert property (@(posedge clk) disable iff (!rst_n_i)
      !(bus_rsp_o.ack && bus_rsp_o.err));

endmodule

`default_nettype wire

//--- hdl/wb_pkg.sv
// Wishbone B3 classic vector types and request and response structs
`default_nettype none

`include "tile_params.svh"

package wb_pkg;

   typedef logic [`WB_AW-1:0] wb_adr_t;
   typedef logic [`WB_DW-1:0] wb_dat_t;
   typedef logic [`WB_SELW-1:0] wb_sel_t;

   // Master to slave
   typedef struct packed {
      wb_adr_t adr;
      wb_dat_t dat;
      wb_sel_t sel;
      logic    we;
      logic    cyc;
      logic    stb;
   } wb_req_t;

   // Slave to master
   typedef struct packed {
      wb_dat_t dat;
      logic    ack;
      logic    err;
   } wb_rsp_t;

endpackage

`default_nettype wire

//--- hdl/wb_sram_sp.sv
// Single-port data memory Wishbone slave with byte-lane writes and registered ack
`timescale 1ns/1ps
`default_nettype none

`include "tile_params.svh"

module wb_sram_sp
   import wb_pkg::*;
#(
   parameter int MEM_SIZE_BYTE = `LMEM_SIZE
) (
   input  wire          clk,
   input  wire          rst_n_i,
   input  wire wb_req_t wb_req_i,
   output wb_rsp_t      wb_rsp_o
);

   localparam int WORDS = MEM_SIZE_BYTE / 4;
   localparam int IDXW  = $clog2(WORDS);

   wb_dat_t          mem [WORDS];
   logic [IDXW-1:0]  idx;
   logic             req_vld;
   logic             ack_q;
   wb_dat_t          rdat_q;

   assign idx     = wb_req_i.adr[IDXW+1:2];  // Word index below the size
   assign req_vld = wb_req_i.cyc && wb_req_i.stb && !ack_q;  // One ack per request

   always_ff @(posedge clk) begin
      if (req_vld && wb_req_i.we) begin
         for (int b = 0; b < `WB_SELW; b++) begin
            if (wb_req_i.sel[b]) begin
               mem[idx][8*b +: 8] <= wb_req_i.dat[8*b +: 8];
            end
         end
      end
      rdat_q <= mem[idx];
   end

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= req_vld;
      end
   end

   assign wb_rsp_o = '{dat: rdat_q, ack: ack_q, err: 1'b0};

   a_ack_after_stb : assert property (@(posedge clk) disable iff (!rst_n_i)
      wb_rsp_o.ack |-> $past(wb_req_i.cyc && wb_req_i.stb));

endmodule

`default_nettype wire

//--- testbench/tb_compute_tile.sv
// Testbench for the compute tile bus core with two masters, reference model and snoop checks
`timescale 1ns/1ps
`default_nettype none

`include "tile_params.svh"

module tb_compute_tile
   import wb_pkg::*;
   import tile_pkg::*;
();

   localparam int IDXW         = $clog2(`LMEM_SIZE / 4);
   localparam int WORDS_PER_M  = 16;  // Words each master owns in the random test
   localparam int N_RAND       = 32;
   localparam int N_XFERS      = 3 + 11 + 9 + 15 + `NR_MASTERS * (WORDS_PER_M + N_RAND);
   localparam int CYC_PER_XFER = 12;  // Worst case behind the other master

   typedef struct packed {
      logic [33:0] exp_rsp;
      logic [33:0] act_rsp;
      logic [33:0] exp_snp;
      logic [33:0] act_snp;
   } chk_t;

   logic                      clk;
   logic                      rst_n_i;
   wb_req_t [`NR_MASTERS-1:0] m_req;
   wb_rsp_t [`NR_MASTERS-1:0] m_rsp;
   logic                      snoop_en;
   wb_adr_t                   snoop_adr;

   wb_dat_t shadow [`LMEM_SIZE / 4];  // Expected data memory contents
   chk_t    checks [$];
   chk_t    popped;
   string   test_name = "reset";
   int      seed = 14456;
   int      wr_acks = 0;
   int      snoop_count = 0;

   compute_tile u_dut (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .m_req_i     (m_req),
      .m_rsp_o     (m_rsp),
      .snoop_en_o  (snoop_en),
      .snoop_adr_o (snoop_adr)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   task automatic value_error(input string what, input logic [33:0] exp, input logic [33:0] act);
      $display("ERROR: test %s, %s expected %h actual %h", test_name, what, exp, act);
      $display("Simulation failed");
      $fatal(1);
   endtask

   // Expected {err, read data} from the address map and the shadow memory
   function automatic logic [32:0] ref_result(input wb_adr_t adr, input logic we);
      region_t region;
      region = adr[`WB_AW-1 -: 4];
      if (region == `DM_MATCH) begin
         return {1'b0, shadow[adr[IDXW+1:2]]};
      end else if (region == `BOOT_MATCH) begin
         return {we, bootrom_image[adr[4:2]]};  // ROM refuses writes
      end
      return {1'b1, 32'h0};
   endfunction

   function automatic void write_shadow(input wb_adr_t adr, input wb_dat_t dat,
                                        input wb_sel_t sel);
      for (int b = 0; b < `WB_SELW; b++) begin
         if (sel[b]) begin
            shadow[adr[IDXW+1:2]][8*b +: 8] = dat[8*b +: 8];
         end
      end
   endfunction

   // One Wishbone classic transfer with its result queued for the checker
   task automatic transfer(input int m, input wb_adr_t adr, input logic we,
                           input wb_dat_t dat, input wb_sel_t sel);
      logic [32:0] expd;
      logic        dm_wr;
      logic        no_dat;
      chk_t        chk;
      @(negedge clk);
      m_req[m] = '{adr: adr, dat: dat, sel: sel, we: we, cyc: 1'b1, stb: 1'b1};
      do @(negedge clk); while (!(m_rsp[m].ack || m_rsp[m].err));
      expd   = ref_result(adr, we);
      dm_wr  = we && !expd[32];
      no_dat = we || expd[32];  // No read data to compare
      chk.exp_rsp = {!expd[32], expd[32], no_dat ? 32'h0 : expd[31:0]};
      chk.act_rsp = {m_rsp[m].ack, m_rsp[m].err, no_dat ? 32'h0 : m_rsp[m].dat};
      chk.exp_snp = {1'b0, dm_wr, dm_wr ? adr : 32'h0};
      chk.act_snp = {1'b0, snoop_en, snoop_en ? snoop_adr : 32'h0};
      if (dm_wr) begin
         write_shadow(adr, dat, sel);
         wr_acks++;
      end
      checks.push_back(chk);
      m_req[m] = '0;
   endtask

   task automatic random_master(input int m);
      wb_adr_t base;
      wb_adr_t adr;
      logic    we;
      base = wb_adr_t'(m * (`LMEM_SIZE / 2));  // Disjoint halves
      for (int i = 0; i < WORDS_PER_M; i++) begin
         transfer(m, base + wb_adr_t'(4 * i), 1'b1, wb_dat_t'($random(seed)), 4'hf);
      end
      for (int i = 0; i < N_RAND; i++) begin
         adr = base + wb_adr_t'(4 * ($random(seed) & (WORDS_PER_M - 1)));
         we  = 1'($random(seed));
         transfer(m, adr, we, wb_dat_t'($random(seed)), wb_sel_t'($random(seed)));
      end
   endtask

   task automatic begin_test(input string name);
      while (checks.size() != 0) @(negedge clk);
      @(negedge clk);
      test_name = name;
   endtask

   always @(posedge clk) begin
      while (checks.size() != 0) begin
         popped = checks.pop_front();
         assert (popped.act_rsp === popped.exp_rsp)
            else value_error("ack, err and data", popped.exp_rsp, popped.act_rsp);
         assert (popped.act_snp === popped.exp_snp)
            else value_error("snoop", popped.exp_snp, popped.act_snp);
      end
   end

   always @(negedge clk) begin
      if (rst_n_i && snoop_en) begin
         snoop_count++;
      end
   end

   initial begin
      repeat (5 + N_XFERS * CYC_PER_XFER) @(posedge clk);
      $display("Watchdog expired, a bus transfer never completed");
      $display("Simulation failed");
      $fatal(1);
   end

   initial begin
      rst_n_i = 1'b0;
      m_req   = '0;
      repeat (5) @(negedge clk);
      rst_n_i = 1'b1;

      begin_test("dm_word");
      transfer(0, 32'h0000_0010, 1'b1, 32'hcafe_f00d, 4'hf);
      transfer(0, 32'h0000_0010, 1'b0, 32'h0, 4'h0);
      transfer(1, 32'h0000_0010, 1'b0, 32'h0, 4'h0);

      begin_test("dm_bytes");
      transfer(0, 32'h0000_0020, 1'b1, 32'h1122_3344, 4'hf);
      for (int i = 1; i < 15; i += 3) begin
         transfer(1, 32'h0000_0020, 1'b1, 32'ha5c3_e10f + wb_dat_t'(i), wb_sel_t'(i));
         transfer(0, 32'h0000_0020, 1'b0, 32'h0, 4'h0);
      end

      begin_test("bootrom");
      for (int i = 0; i < `BOOTROM_WORDS; i++) begin
         transfer(i % 2, 32'hf000_0000 + wb_adr_t'(4 * i), 1'b0, 32'h0, 4'h0);
      end
      transfer(0, 32'hf000_0008, 1'b1, 32'h1234_5678, 4'hf);

      begin_test("unmapped");
      for (int n = 1; n < 15; n++) begin
         transfer(n % 2, {region_t'(n), 28'h000_0010}, 1'(n % 2), 32'hffff_ffff, 4'hf);
      end
      transfer(0, 32'h0000_0010, 1'b0, 32'h0, 4'h0);  // Memory untouched

      begin_test("random_both");
      fork
         random_master(0);
         random_master(1);
      join

      begin_test("snoop_count");
      assert (snoop_count == wr_acks)
         else value_error("snoop pulses", 34'(wr_acks), 34'(snoop_count));
      $display("Simulation passed");
      $finish;
   end

endmodule

`default_nettype wire
